//--- design/plot_pkg.sv
// Shared plotter types; coordinates are 8-bit unsigned, so the drawing area is 256 x 256.
package plot_pkg;

    localparam int coord_w = 8;  // matches the 8-bit x and y of the ROM.

    typedef logic [coord_w-1:0] coord_t;

    // one ROM word, packed as x, y, line, pos.
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   line;  // draw to this point.
        logic   pos;   // move without drawing.
    } vec_cmd_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_t;

    typedef struct packed {
        pixel_t from;
        pixel_t to;
    } seg_t;

    // both flags set ends the program.
    typedef enum logic [1:0] {
        seq_idle,
        seq_fetch,
        seq_wait_line
    } seq_state_t;

    typedef enum logic {
        ras_idle,
        ras_step
    } ras_state_t;

endpackage

//--- design/mtm_rom.sv
// Combinational logo ROM; any address past entry 65 reads as the end-of-program marker.
module mtm_rom #(
    parameter int addr_width = 7
) (
    input  logic [addr_width-1:0] addr,
    output plot_pkg::vec_cmd_t    data_out
);
    import plot_pkg::*;

    function automatic vec_cmd_t mv(input int unsigned x, input int unsigned y);
        mv = '{x: coord_t'(x), y: coord_t'(y), line: 1'b0, pos: 1'b1};
    endfunction

    function automatic vec_cmd_t ln(input int unsigned x, input int unsigned y);
        ln = '{x: coord_t'(x), y: coord_t'(y), line: 1'b1, pos: 1'b0};
    endfunction

    function automatic vec_cmd_t stop(input int unsigned x, input int unsigned y);
        stop = '{x: coord_t'(x), y: coord_t'(y), line: 1'b1, pos: 1'b1};
    endfunction

    always_comb begin
        unique case (addr)
            0:  data_out = mv(32, 98);  // small left ring.
            1:  data_out = ln(33, 94);
            2:  data_out = ln(35, 92);
            3:  data_out = ln(41, 92);
            4:  data_out = ln(44, 95);
            5:  data_out = ln(44, 101);
            6:  data_out = ln(41, 104);
            7:  data_out = ln(35, 104);
            8:  data_out = ln(32, 98);
            9:  data_out = mv(32, 173);  // main letter outline.
            10: data_out = ln(37, 175);
            11: data_out = ln(63, 175);
            12: data_out = ln(66, 172);
            13: data_out = ln(80, 128);
            14: data_out = ln(83, 125);
            15: data_out = ln(87, 126);
            16: data_out = ln(103, 172);
            17: data_out = ln(107, 175);
            18: data_out = ln(155, 175);
            19: data_out = ln(159, 170);
            20: data_out = ln(175, 126);
            21: data_out = ln(177, 125);
            22: data_out = ln(180, 128);
            23: data_out = ln(195, 172);
            24: data_out = ln(198, 175);
            25: data_out = ln(226, 175);
            26: data_out = ln(229, 172);
            27: data_out = ln(229, 167);
            28: data_out = ln(226, 163);
            29: data_out = ln(199, 163);
            30: data_out = ln(197, 161);
            31: data_out = ln(183, 116);
            32: data_out = ln(180, 113);
            33: data_out = ln(173, 113);
            34: data_out = ln(169, 118);
            35: data_out = ln(156, 160);
            36: data_out = ln(152, 163);
            37: data_out = ln(140, 163);
            38: data_out = ln(137, 160);
            39: data_out = ln(137, 95);
            40: data_out = ln(134, 92);
            41: data_out = ln(127, 92);
            42: data_out = ln(124, 95);
            43: data_out = ln(123, 160);
            44: data_out = ln(119, 163);
            45: data_out = ln(107, 163);
            46: data_out = ln(104, 157);
            47: data_out = ln(90, 117);
            48: data_out = ln(88, 113);
            49: data_out = ln(81, 113);
            50: data_out = ln(76, 118);
            51: data_out = ln(64, 160);
            52: data_out = ln(59, 163);
            53: data_out = ln(35, 163);
            54: data_out = ln(32, 167);
            55: data_out = ln(32, 173);
            56: data_out = mv(217, 99);  // small right ring.
            57: data_out = ln(220, 104);
            58: data_out = ln(225, 104);
            59: data_out = ln(228, 100);
            60: data_out = ln(229, 95);
            61: data_out = ln(226, 92);
            62: data_out = ln(219, 92);
            63: data_out = ln(217, 95);
            64: data_out = ln(217, 99);
            65: data_out = stop(217, 99);
            default: data_out = stop(0, 0);
        endcase
    end

endmodule

//--- design/line_rasterizer.sv
// Bresenham engine; one pixel per cycle with no stall, start point excluded, zero-length segments not allowed.
module line_rasterizer (
    input  logic             clk,
    input  logic             rst,
    input  logic             line_start,
    input  plot_pkg::seg_t   seg,
    output logic             pixel_valid,
    output logic             line_done,
    output plot_pkg::pixel_t pixel
);
    import plot_pkg::*;

    localparam int dw = coord_w + 2;  // signed delta width.
    localparam int ew = coord_w + 4;  // error term, holds twice the delta.

    ras_state_t state;

    pixel_t cur;  // last emitted point.
    pixel_t end_pt;
    pixel_t org;
    logic signed [dw-1:0] dx;  // +|dx|.
    logic signed [dw-1:0] dy;  // -|dy|.
    logic sx_neg;
    logic sy_neg;
    logic signed [ew-1:0] err;

    logic signed [dw-1:0] dx_raw;
    logic signed [dw-1:0] dy_raw;
    logic signed [dw-1:0] adx;
    logic signed [dw-1:0] ady;
    logic signed [ew-1:0] dx_e;
    logic signed [ew-1:0] dy_e;
    logic signed [ew-1:0] e2;
    logic signed [ew-1:0] nxt_err;
    logic step_x;
    logic step_y;
    pixel_t nxt;

    // deltas of the incoming segment.
    always_comb begin
        dx_raw = $signed({2'b00, seg.to.x}) - $signed({2'b00, seg.from.x});
        dy_raw = $signed({2'b00, seg.to.y}) - $signed({2'b00, seg.from.y});
        adx = dx_raw[dw-1] ? -dx_raw : dx_raw;
        ady = dy_raw[dw-1] ? -dy_raw : dy_raw;
    end

    // one Bresenham step from cur.
    always_comb begin
        dx_e = dx;
        dy_e = dy;
        e2 = err <<< 1;
        step_x = (e2 >= dy_e);
        step_y = (e2 <= dx_e);
        nxt = cur;
        nxt_err = err;
        if (step_x) begin
            nxt.x = sx_neg ? cur.x - 1'b1 : cur.x + 1'b1;
            nxt_err = nxt_err + dy_e;
        end
        if (step_y) begin
            nxt.y = sy_neg ? cur.y - 1'b1 : cur.y + 1'b1;
            nxt_err = nxt_err + dx_e;
        end
    end

    assign pixel_valid = (state == ras_step);
    assign pixel       = nxt;
    assign line_done   = pixel_valid && (nxt == end_pt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ras_idle;
        end else begin
            unique case (state)
                ras_idle: if (line_start) state <= ras_step;
                ras_step: if (line_done) state <= ras_idle;
                default:  state <= ras_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ras_idle && line_start) begin
            cur    <= seg.from;
            org    <= seg.from;
            end_pt <= seg.to;
            dx     <= adx;
            dy     <= -ady;
            sx_neg <= dx_raw[dw-1];
            sy_neg <= dy_raw[dw-1];
            err    <= adx - ady;
        end else if (state == ras_step) begin
            cur <= nxt;
            err <= nxt_err;
        end
    end

    // sequencer must wait for line_done before the next segment.
    a_no_start_in_step: assert property (
        @(posedge clk) disable iff (rst) (state == ras_step) |-> !line_start);

    a_pixel_in_box: assert property (
        @(posedge clk) disable iff (rst) pixel_valid |->
            ((pixel.x >= org.x && pixel.x <= end_pt.x) ||
             (pixel.x <= org.x && pixel.x >= end_pt.x)) &&
            ((pixel.y >= org.y && pixel.y <= end_pt.y) ||
             (pixel.y <= org.y && pixel.y >= end_pt.y)));

endmodule

//--- design/logo_sequencer.sv
// Drawing program FSM; start honoured only in idle; done and line_start decode the current entry.
module logo_sequencer #(
    parameter int addr_width = 7
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  plot_pkg::vec_cmd_t    cmd,
    input  logic                  line_done,
    output logic [addr_width-1:0] addr,
    output plot_pkg::seg_t        seg,
    output logic                  line_start,
    output logic                  busy,
    output logic                  done
);
    import plot_pkg::*;

    seq_state_t state;
    pixel_t     pen;

    pixel_t target;
    logic   in_fetch;
    logic   is_end;
    logic   is_draw;
    logic   moves_pen;

    always_comb begin
        target    = '{x: cmd.x, y: cmd.y};
        in_fetch  = (state == seq_fetch);
        is_end    = cmd.line && cmd.pos;
        moves_pen = cmd.line || cmd.pos;
        is_draw   = cmd.line && !cmd.pos && (target != pen);  // zero length acts as a move.
    end

    always_comb begin
        seg        = '{from: pen, to: target};
        line_start = in_fetch && is_draw;
        done       = in_fetch && is_end;
        busy       = (state != seq_idle) && !done;  // low already in the done cycle.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_idle;
            addr  <= '0;
            pen   <= '0;
        end else begin
            unique case (state)
                seq_idle: begin
                    if (start) begin
                        state <= seq_fetch;
                        addr  <= '0;
                        pen   <= '0;
                    end
                end
                seq_fetch: begin
                    if (is_end) begin
                        state <= seq_idle;
                    end else begin
                        if (moves_pen) pen <= target;
                        if (is_draw) state <= seq_wait_line;
                        else addr <= addr + 1'b1;  // move or skip in one cycle.
                    end
                end
                seq_wait_line: begin
                    if (line_done) begin
                        state <= seq_fetch;
                        addr  <= addr + 1'b1;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // rasterizer finishes only a segment this FSM launched.
    a_line_done_in_wait: assert property (
        @(posedge clk) disable iff (rst) line_done |-> (state == seq_wait_line));

endmodule

//--- design/logo_plotter.sv
// Plotter top; no back-pressure, so the consumer must accept one pixel every cycle while busy.
module logo_plotter #(
    parameter int addr_width = 7
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    output logic             busy,
    output logic             pixel_valid,
    output plot_pkg::pixel_t pixel,
    output logic             done
);
    import plot_pkg::*;

    logic [addr_width-1:0] addr;
    vec_cmd_t              cmd;
    seg_t                  seg;
    logic                  line_start;
    logic                  line_done;

    mtm_rom #(
        .addr_width(addr_width)
    ) mtm_rom_i (
        .addr    (addr),
        .data_out(cmd)
    );

    logo_sequencer #(
        .addr_width(addr_width)
    ) logo_sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cmd       (cmd),
        .line_done (line_done),
        .addr      (addr),
        .seg       (seg),
        .line_start(line_start),
        .busy      (busy),
        .done      (done)
    );

    line_rasterizer line_rasterizer_i (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .seg        (seg),
        .pixel_valid(pixel_valid),
        .line_done  (line_done),
        .pixel      (pixel)
    );

endmodule

//--- tests/clk_gen.sv
// Free-running clock, 50% duty cycle, low at time zero; period must be even.
module clk_gen #(
    parameter int period = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2);
        clk = ~clk;  // half period per phase.
    end

endmodule

//--- tests/logo_ref.svh
// Reference drawing model; include inside a module that imports plot_pkg and declares exp_q.
`ifndef logo_ref_svh
`define logo_ref_svh

localparam int prog_len = 66;

// one row per entry as x, y, kind; kind bit 0 is pos, bit 1 is line.
localparam int prog_tab [prog_len][3] = '{
    '{32, 98, 1}, '{33, 94, 2}, '{35, 92, 2}, '{41, 92, 2}, '{44, 95, 2},
    '{44, 101, 2}, '{41, 104, 2}, '{35, 104, 2}, '{32, 98, 2}, '{32, 173, 1},
    '{37, 175, 2}, '{63, 175, 2}, '{66, 172, 2}, '{80, 128, 2}, '{83, 125, 2},
    '{87, 126, 2}, '{103, 172, 2}, '{107, 175, 2}, '{155, 175, 2}, '{159, 170, 2},
    '{175, 126, 2}, '{177, 125, 2}, '{180, 128, 2}, '{195, 172, 2}, '{198, 175, 2},
    '{226, 175, 2}, '{229, 172, 2}, '{229, 167, 2}, '{226, 163, 2}, '{199, 163, 2},
    '{197, 161, 2}, '{183, 116, 2}, '{180, 113, 2}, '{173, 113, 2}, '{169, 118, 2},
    '{156, 160, 2}, '{152, 163, 2}, '{140, 163, 2}, '{137, 160, 2}, '{137, 95, 2},
    '{134, 92, 2}, '{127, 92, 2}, '{124, 95, 2}, '{123, 160, 2}, '{119, 163, 2},
    '{107, 163, 2}, '{104, 157, 2}, '{90, 117, 2}, '{88, 113, 2}, '{81, 113, 2},
    '{76, 118, 2}, '{64, 160, 2}, '{59, 163, 2}, '{35, 163, 2}, '{32, 167, 2},
    '{32, 173, 2}, '{217, 99, 1}, '{220, 104, 2}, '{225, 104, 2}, '{228, 100, 2},
    '{229, 95, 2}, '{226, 92, 2}, '{219, 92, 2}, '{217, 95, 2}, '{217, 99, 2},
    '{217, 99, 3}
};

// Bresenham walk, start point left out, end point included.
function automatic void draw_segment(input int x0, input int y0, input int x1, input int y1);
    int dx;
    int dy;
    int sx;
    int sy;
    int err;
    int e2;
    int x;
    int y;
    pixel_t p;
    dx = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative.
    sx = (x1 >= x0) ? 1 : -1;
    sy = (y1 >= y0) ? 1 : -1;
    err = dx + dy;
    x = x0;
    y = y0;
    while (x != x1 || y != y1) begin
        e2 = 2 * err;
        if (e2 >= dy) begin
            err = err + dy;
            x = x + sx;
        end
        if (e2 <= dx) begin
            err = err + dx;
            y = y + sy;
        end
        p.x = coord_t'(x);
        p.y = coord_t'(y);
        exp_q.push_back(p);
    end
endfunction

// pen starts at the origin; moves and zero-length lines only shift the pen.
function automatic void build_expected();
    int pen_x;
    int pen_y;
    bit pos;
    bit line;
    pen_x = 0;
    pen_y = 0;
    exp_q.delete();
    for (int i = 0; i < prog_len; i++) begin
        pos = prog_tab[i][2][0];
        line = prog_tab[i][2][1];
        if (pos && line) break;  // end of program.
        if (line && (prog_tab[i][0] != pen_x || prog_tab[i][1] != pen_y)) begin
            draw_segment(pen_x, pen_y, prog_tab[i][0], prog_tab[i][1]);
        end
        if (pos || line) begin
            pen_x = prog_tab[i][0];
            pen_y = prog_tab[i][1];
        end
    end
endfunction

`endif

//--- tests/logo_plotter_tb.sv
// Testbench for logo_plotter; samples every cycle, inputs change 1 unit after the edge.
module logo_plotter_tb;
    import plot_pkg::*;

    localparam int frame_slack = 300;  // cycles beyond the pixel count.

    logic   clk;
    logic   rst;
    logic   start;
    logic   busy;
    logic   pixel_valid;
    pixel_t pixel;
    logic   done;

    pixel_t exp_q[$];
    int     pix_idx = 0;
    int     done_cnt = 0;

    `include "logo_ref.svh"

    clk_gen #(
        .period(10)
    ) clk_gen_i (
        .clk(clk)
    );

    logo_plotter #(
        .addr_width(7)
    ) logo_plotter_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .pixel_valid(pixel_valid),
        .pixel      (pixel),
        .done       (done)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_pixel(input pixel_t got, input pixel_t exp, input int idx);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: pixel %0d is (%0d,%0d), expected (%0d,%0d)",
                $time, idx, got.x, got.y, exp.x, exp.y));
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    // monitor, owns the per-frame counters.
    always @(negedge clk) begin
        if (!rst) begin
            if (start && !busy && !done) begin
                pix_idx = 0;  // new frame accepted.
                done_cnt = 0;
            end
            if (pixel_valid) begin
                compare_flag(busy, 1'b1, "busy with a pixel");
                if (pix_idx >= exp_q.size()) begin
                    fail_run($sformatf("** Error at %0t: pixel beyond the expected %0d",
                        $time, exp_q.size()));
                end
                compare_pixel(pixel, exp_q[pix_idx], pix_idx);
                pix_idx++;
            end
            if (done) done_cnt++;
        end
    end

    // one frame; poke adds stray start pulses while busy.
    task automatic run_frame(input bit poke);
        int cycles;
        cycles = 0;
        start = 1'b1;
        wait_cycle();  // monitor clears the counters on this start.
        while (done_cnt == 0) begin
            if (cycles > exp_q.size() + frame_slack) begin
                fail_run($sformatf("timeout: no done pulse within %0d cycles", cycles));
            end
            start = poke && ($urandom_range(0, 7) == 0);
            wait_cycle();
            cycles++;
        end
        start = 1'b0;
        repeat (4) wait_cycle();  // room for a stray second done.
        compare_count(pix_idx, exp_q.size(), "pixels per frame");
        compare_count(done_cnt, 1, "done pulses per frame");
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3, 40)) wait_cycle();
    endtask

    task automatic reset_mid_frame();
        int run_cycles;
        run_cycles = $urandom_range(20, exp_q.size() - 1);
        start = 1'b1;
        wait_cycle();
        start = 1'b0;
        repeat (run_cycles) wait_cycle();
        compare_count(done_cnt, 0, "done pulses before reset");
        rst = 1'b1;
        @(posedge clk);
        @(negedge clk);
        compare_flag(busy, 1'b0, "busy in reset");
        compare_flag(pixel_valid, 1'b0, "pixel_valid in reset");
        wait_cycle();
        rst = 1'b0;
        wait_cycle();
    endtask

    initial begin
        void'($urandom(80));
        rst = 1'b1;
        start = 1'b0;
        build_expected();
        if (exp_q.size() == 0) fail_run("reference program produced no pixels");
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        wait_cycle();
        run_frame(1'b0);
        idle_gap();
        run_frame(1'b1);  // starts while busy are ignored.
        idle_gap();
        run_frame(1'b0);
        reset_mid_frame();
        run_frame(1'b0);  // clean frame after reset.
        $display("Test OK");
        $finish;
    end

endmodule

//--- list.f
+incdir+tests
design/plot_pkg.sv
design/mtm_rom.sv
design/line_rasterizer.sv
design/logo_sequencer.sv
design/logo_plotter.sv
tests/clk_gen.sv
tests/logo_plotter_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module logo_plotter_tb \
    -f list.f -o logo_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/logo_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
